/* Makefile */
FLIST = sample_buffer_top.f

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f $(FLIST) --top-module sample_buffer_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f $(FLIST) \
		--top-module sample_buffer_tb -o sim_tb
	out=$$(./obj_dir/sim_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

/* bench/sample_buffer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sample_buffer_macros.svh"

module sample_buffer_tb
    import sample_buffer_pkg::*;
();

    localparam int DEPTH = `SB_FIFO_DEPTH;
    localparam int ROUNDS = 6;
    localparam int ROUND_CYCLES = 60;
    localparam int OVERFILL = 5;
    // Register transfers in the run, each allowed up to 24 cycles of stalls
    localparam int REG_OPS = 36;
    localparam int TEST_CYCLES = ROUNDS * ROUND_CYCLES + 100 + REG_OPS * 24;
    localparam int CYCLE_LIMIT = 4 * TEST_CYCLES + 200;

    logic        clk_i;
    logic        reset_ni;
    axil_addr_t  s_axil_awaddr_i;
    logic        s_axil_awvalid_i;
    logic        s_axil_awready_o;
    axil_data_t  s_axil_wdata_i;
    logic [3:0]  s_axil_wstrb_i;
    logic        s_axil_wvalid_i;
    logic        s_axil_wready_o;
    logic [1:0]  s_axil_bresp_o;
    logic        s_axil_bvalid_o;
    logic        s_axil_bready_i;
    axil_addr_t  s_axil_araddr_i;
    logic        s_axil_arvalid_i;
    logic        s_axil_arready_o;
    axil_data_t  s_axil_rdata_o;
    logic [1:0]  s_axil_rresp_o;
    logic        s_axil_rvalid_o;
    logic        s_axil_rready_i;
    logic        in_valid_i;
    beat_t       in_beat_i;
    logic        in_full_o;
    logic        out_ready_i;
    logic        out_valid_o;
    beat_t       out_beat_o;
    logic        irq_o;

    // Reference model of the buffer contents and the register state
    beat_t       model_q[$];
    beat_t       exp_beat;
    logic        exp_valid;
    logic        model_enable;
    int unsigned model_drops;
    level_t      model_wmark;
    logic [16:0] lfsr;
    int          value_errors;
    int          protocol_errors;
    int          cycle_count;

    sample_buffer_top u_dut (.*);

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    // Taps at bits 17 and 14 give a maximal-length sequence
    function automatic logic [16:0] lfsr_step(input logic [16:0] state);
        return {state[15:0], state[16] ^ state[13]};
    endfunction

    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    // STATUS layout is level in bits 4:0, empty in bit 8 and full in bit 9
    function automatic axil_data_t expected_status();
        axil_data_t word;
        word = '0;
        word[4:0] = model_q.size();
        word[8] = (model_q.size() == 0);
        word[9] = (model_q.size() == DEPTH);
        return word;
    endfunction

    function automatic logic expected_irq();
        return model_enable && (model_q.size() >= model_wmark);
    endfunction

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        $display("Error at time %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, expected);
        value_errors++;
    endtask

    task automatic report_protocol(input string what);
        $display("Protocol failure at time %0t: %s", $time, what);
        protocol_errors++;
    endtask

    // One clock edge, then the consumer port is compared with the read planned for it
    task automatic tick();
        @(posedge clk_i);
        #1;
        if (out_valid_o !== exp_valid) report_value("out_valid_o", out_valid_o, exp_valid);
        if (exp_valid && out_beat_o.data !== exp_beat.data)
            report_value("out_beat_o.data", out_beat_o.data, exp_beat.data);
        if (exp_valid && out_beat_o.tag !== exp_beat.tag)
            report_value("out_beat_o.tag", out_beat_o.tag, exp_beat.tag);
        exp_valid = 1'b0;
    endtask

    // Full and empty are judged on the occupancy before this edge
    task automatic drive_stream(input logic valid, input logic ready);
        beat_t beat;
        beat.data = sample_t'(rand_bits(`SB_DATA_WIDTH));
        beat.tag = user_t'(rand_bits(`SB_USER_WIDTH));
        in_valid_i = valid;
        in_beat_i = beat;
        out_ready_i = ready;
        exp_valid = ready && (model_q.size() > 0);
        if (exp_valid) exp_beat = model_q[0];
        if (model_enable && valid && model_q.size() < DEPTH) model_q.push_back(beat);
        else if (model_enable && valid) model_drops++;
        if (exp_valid) void'(model_q.pop_front());
    endtask

    task automatic run_stream(input int cycles, input logic fill_bias);
        logic valid;
        logic ready;
        for (int i = 0; i < cycles; i++) begin
            valid = (rand_bits(1) != 0) && (model_q.size() < DEPTH - 1);
            ready = fill_bias ? (rand_bits(2) == 0) : (rand_bits(2) != 0);
            drive_stream(valid, ready);
            tick();
        end
    endtask

    // Stream goes idle and the status and interrupt registers catch up
    task automatic settle();
        drive_stream(1'b0, 1'b0);
        tick();
        tick();
    endtask

    task automatic reg_write(input axil_addr_t addr, input axil_data_t data);
        logic taken;
        s_axil_awaddr_i = addr;
        s_axil_wdata_i = data;
        s_axil_awvalid_i = 1'b1;
        s_axil_wvalid_i = 1'b1;
        do tick(); while (!s_axil_awready_o);
        if (s_axil_wready_o !== 1'b1) report_value("s_axil_wready_o", s_axil_wready_o, 1);
        // Address and data are taken at the next edge
        tick();
        s_axil_awvalid_i = 1'b0;
        s_axil_wvalid_i = 1'b0;
        taken = !s_axil_bvalid_o;
        if (taken) report_protocol("no write response after the handshake");
        while (!taken) begin
            if (!s_axil_bvalid_o) report_protocol("write response dropped before bready");
            if (s_axil_bresp_o !== 2'b00) report_value("s_axil_bresp_o", s_axil_bresp_o, 0);
            s_axil_bready_i = (rand_bits(1) != 0);
            taken = s_axil_bready_i || !s_axil_bvalid_o;
            tick();
        end
        s_axil_bready_i = 1'b0;
        if (s_axil_bvalid_o) report_protocol("a second write response appeared");
    endtask

    task automatic read_check(input axil_addr_t addr, input axil_data_t expected,
                              input string name);
        logic       taken;
        axil_data_t data;
        data = '0;
        s_axil_araddr_i = addr;
        s_axil_arvalid_i = 1'b1;
        do tick(); while (!s_axil_arready_o);
        tick();
        s_axil_arvalid_i = 1'b0;
        taken = !s_axil_rvalid_o;
        if (taken) report_protocol("no read data after the handshake");
        while (!taken) begin
            if (!s_axil_rvalid_o) report_protocol("read data dropped before rready");
            if (s_axil_rresp_o !== 2'b00) report_value("s_axil_rresp_o", s_axil_rresp_o, 0);
            data = s_axil_rdata_o;
            s_axil_rready_i = (rand_bits(1) != 0);
            taken = s_axil_rready_i;
            tick();
        end
        s_axil_rready_i = 1'b0;
        if (s_axil_rvalid_o) report_protocol("a second read response appeared");
        if (data !== expected) report_value(name, data, expected);
    endtask

    initial begin
        clk_i = 1'b0;
        reset_ni = 1'b0;
        lfsr = 17'd86252;
        {value_errors, protocol_errors, cycle_count} = '0;
        {model_enable, model_drops, model_wmark, exp_valid, exp_beat} = '0;
        {s_axil_awaddr_i, s_axil_awvalid_i, s_axil_wdata_i, s_axil_wvalid_i} = '0;
        {s_axil_bready_i, s_axil_araddr_i, s_axil_arvalid_i, s_axil_rready_i} = '0;
        s_axil_wstrb_i = 4'hF;
        {in_valid_i, in_beat_i, out_ready_i} = '0;
        repeat (5) @(posedge clk_i);
        #1;
        reset_ni = 1'b1;
        if (irq_o !== 1'b0) report_value("irq_o", irq_o, 0);
        if (in_full_o !== 1'b0) report_value("in_full_o", in_full_o, 0);
        if (s_axil_bvalid_o || s_axil_rvalid_o) report_protocol("AXI response valid after reset");
        read_check(REG_STATUS, expected_status(), "STATUS after reset");
        read_check(REG_WMARK, 32'h0, "WMARK after reset");
        reg_write(REG_CTRL, 32'h1);
        model_enable = 1'b1;

        // Random traffic rounds, each with a fresh watermark
        for (int r = 0; r < ROUNDS; r++) begin
            model_wmark = level_t'(rand_bits(5) % (DEPTH + 1));
            reg_write(REG_WMARK, model_wmark);
            read_check(REG_WMARK, model_wmark, "WMARK readback");
            read_check(REG_CTRL, model_enable, "CTRL readback");
            run_stream(ROUND_CYCLES, r[0]);
            settle();
            if (irq_o !== expected_irq()) report_value("irq_o", irq_o, expected_irq());
            read_check(REG_STATUS, expected_status(), "STATUS after traffic");
        end

        reg_write(REG_CTRL, 32'h0);
        model_enable = 1'b0;
        for (int i = 0; i < 20; i++) begin
            drive_stream(rand_bits(1) != 0, 1'b0);
            tick();
        end
        settle();
        if (irq_o !== expected_irq()) report_value("irq_o", irq_o, expected_irq());
        read_check(REG_STATUS, expected_status(), "STATUS with intake disabled");

        // Overfill with the consumer stalled, then drain
        reg_write(REG_CTRL, 32'h3);
        model_q.delete();
        model_drops = 0;
        model_enable = 1'b1;
        for (int i = 0; i < DEPTH + OVERFILL; i++) begin
            drive_stream(1'b1, 1'b0);
            tick();
        end
        settle();
        if (in_full_o !== 1'b1) report_value("in_full_o", in_full_o, 1);
        read_check(REG_DROPS, model_drops, "DROPS after overfill");
        read_check(REG_STATUS, expected_status(), "STATUS when full");
        for (int i = 0; i < DEPTH + 2; i++) begin
            drive_stream(1'b0, 1'b1);
            tick();
        end

        // Clear with entries stored and a nonzero drop count
        for (int i = 0; i < 5; i++) begin
            drive_stream(1'b1, 1'b0);
            tick();
        end
        settle();
        reg_write(REG_CTRL, 32'h3);
        model_q.delete();
        model_drops = 0;
        tick();
        tick();
        read_check(REG_STATUS, expected_status(), "STATUS after clear");
        read_check(REG_DROPS, model_drops, "DROPS after clear");
        for (int i = 0; i < 8; i++) begin
            drive_stream(1'b0, 1'b1);
            tick();
        end
        settle();
        read_check(4'h2, 32'h0, "unmapped register");

        $display("Checks done: %0d value errors, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* include/sample_buffer_macros.svh */
`ifndef SAMPLE_BUFFER_MACROS_SVH
`define SAMPLE_BUFFER_MACROS_SVH

// Sample payload and sideband tag widths
`define SB_DATA_WIDTH 16
`define SB_USER_WIDTH 2

// FIFO depth must be a power of two, the pointer width is its log2
`define SB_FIFO_DEPTH 16
`define SB_PTR_WIDTH 4
// One bit more than the pointer so a full FIFO can be counted
`define SB_LEVEL_WIDTH 5

`define SB_AXIL_ADDR_WIDTH 4

`endif

/* sample_buffer_top.f */
+incdir+include
verilog/sample_buffer_pkg.sv
verilog/stream_fifo.sv
verilog/buffer_regs.sv
verilog/sample_buffer_top.sv
bench/sample_buffer_tb.sv

/* verilog/buffer_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sample_buffer_macros.svh"

module buffer_regs
    import sample_buffer_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        reset_ni,

    input  wire axil_addr_t  s_axil_awaddr_i,
    input  wire logic        s_axil_awvalid_i,
    output logic             s_axil_awready_o,
    input  wire axil_data_t  s_axil_wdata_i,
    input  wire logic [3:0]  s_axil_wstrb_i,
    input  wire logic        s_axil_wvalid_i,
    output logic             s_axil_wready_o,
    output logic [1:0]       s_axil_bresp_o,
    output logic             s_axil_bvalid_o,
    input  wire logic        s_axil_bready_i,
    input  wire axil_addr_t  s_axil_araddr_i,
    input  wire logic        s_axil_arvalid_i,
    output logic             s_axil_arready_o,
    output axil_data_t       s_axil_rdata_o,
    output logic [1:0]       s_axil_rresp_o,
    output logic             s_axil_rvalid_o,
    input  wire logic        s_axil_rready_i,

    input  wire fifo_status_t status_i,
    output fifo_ctrl_t       ctrl_o,
    output logic             irq_o
);

    localparam logic [1:0] RESP_OKAY = 2'b00;

    logic       aw_take;
    logic       ar_take;
    logic       wr_en;
    logic       rd_en;
    logic       clear_req;
    level_t     wmark;
    axil_data_t drop_count;
    axil_data_t rd_word;

    // Ready goes up for one cycle only, once address and data are both
    // present and the previous response has been taken
    assign aw_take = s_axil_awvalid_i && s_axil_wvalid_i && !s_axil_bvalid_o &&
                     !s_axil_awready_o;
    assign ar_take = s_axil_arvalid_i && !s_axil_rvalid_o && !s_axil_arready_o;

    assign wr_en = s_axil_awready_o && s_axil_awvalid_i && s_axil_wvalid_i;
    assign rd_en = s_axil_arready_o && s_axil_arvalid_i;

    assign clear_req = wr_en && s_axil_wstrb_i[0] && (s_axil_awaddr_i == REG_CTRL) &&
                       s_axil_wdata_i[1];

    assign s_axil_bresp_o = RESP_OKAY;
    assign s_axil_rresp_o = RESP_OKAY;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            s_axil_awready_o <= 1'b0;
            s_axil_wready_o  <= 1'b0;
            s_axil_bvalid_o  <= 1'b0;
        end else begin
            s_axil_awready_o <= aw_take;
            s_axil_wready_o  <= aw_take;
            if (wr_en) begin
                s_axil_bvalid_o <= 1'b1;
            end else if (s_axil_bready_i) begin
                s_axil_bvalid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            ctrl_o <= '0;
            wmark  <= '0;
        end else begin
            ctrl_o.clear <= clear_req;
            if (wr_en && s_axil_wstrb_i[0]) begin
                case (s_axil_awaddr_i)
                    REG_CTRL: ctrl_o.enable <= s_axil_wdata_i[0];
                    REG_WMARK: wmark <= s_axil_wdata_i[`SB_LEVEL_WIDTH-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Saturates at all ones rather than wrapping back to a small count
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            drop_count <= '0;
        end else if (clear_req) begin
            drop_count <= '0;
        end else if (status_i.drop && (drop_count != '1)) begin
            drop_count <= drop_count + 1'b1;
        end
    end

    always_comb begin
        rd_word = '0;
        case (s_axil_araddr_i)
            REG_CTRL: rd_word[0] = ctrl_o.enable;
            REG_STATUS: begin
                rd_word[`SB_LEVEL_WIDTH-1:0] = status_i.level;
                rd_word[8] = status_i.empty;
                rd_word[9] = status_i.full;
            end
            REG_DROPS: rd_word = drop_count;
            REG_WMARK: rd_word[`SB_LEVEL_WIDTH-1:0] = wmark;
            default: rd_word = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            s_axil_arready_o <= 1'b0;
            s_axil_rvalid_o  <= 1'b0;
        end else begin
            s_axil_arready_o <= ar_take;
            if (rd_en) begin
                s_axil_rvalid_o <= 1'b1;
            end else if (s_axil_rready_i) begin
                s_axil_rvalid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            s_axil_rdata_o <= rd_word;
        end
    end

    // Level-triggered, follows the registered status by one cycle
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            irq_o <= 1'b0;
        end else begin
            irq_o <= ctrl_o.enable && (status_i.level >= wmark);
        end
    end

    a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!reset_ni)
        s_axil_bvalid_o && !s_axil_bready_i |=> s_axil_bvalid_o);

    // The read word must also stay put while the host stalls
    a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!reset_ni)
        s_axil_rvalid_o && !s_axil_rready_i |=> s_axil_rvalid_o && $stable(s_axil_rdata_o));

endmodule

`default_nettype wire

/* verilog/sample_buffer_pkg.sv */
`default_nettype none

`include "sample_buffer_macros.svh"

package sample_buffer_pkg;

    typedef logic [`SB_DATA_WIDTH-1:0] sample_t;
    typedef logic [`SB_USER_WIDTH-1:0] user_t;
    typedef logic [`SB_LEVEL_WIDTH-1:0] level_t;
    typedef logic [`SB_AXIL_ADDR_WIDTH-1:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;

    // One stream transfer, as stored in the FIFO memory
    typedef struct packed {
        sample_t data;
        user_t   tag;
    } beat_t;

    // Clear is a single-cycle pulse
    typedef struct packed {
        logic enable;
        logic clear;
    } fifo_ctrl_t;

    typedef struct packed {
        level_t level;
        logic   empty;
        logic   full;
        logic   drop;
    } fifo_status_t;

    // Register byte offsets on the AXI4-Lite port
    localparam axil_addr_t REG_CTRL   = 4'h0;
    localparam axil_addr_t REG_STATUS = 4'h4;
    localparam axil_addr_t REG_DROPS  = 4'h8;
    localparam axil_addr_t REG_WMARK  = 4'hC;

endpackage

`default_nettype wire

/* verilog/sample_buffer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_buffer_top
    import sample_buffer_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        reset_ni,

    input  wire axil_addr_t  s_axil_awaddr_i,
    input  wire logic        s_axil_awvalid_i,
    output logic             s_axil_awready_o,
    input  wire axil_data_t  s_axil_wdata_i,
    input  wire logic [3:0]  s_axil_wstrb_i,
    input  wire logic        s_axil_wvalid_i,
    output logic             s_axil_wready_o,
    output logic [1:0]       s_axil_bresp_o,
    output logic             s_axil_bvalid_o,
    input  wire logic        s_axil_bready_i,
    input  wire axil_addr_t  s_axil_araddr_i,
    input  wire logic        s_axil_arvalid_i,
    output logic             s_axil_arready_o,
    output axil_data_t       s_axil_rdata_o,
    output logic [1:0]       s_axil_rresp_o,
    output logic             s_axil_rvalid_o,
    input  wire logic        s_axil_rready_i,

    input  wire logic        in_valid_i,
    input  wire beat_t       in_beat_i,
    output logic             in_full_o,

    input  wire logic        out_ready_i,
    output logic             out_valid_o,
    output beat_t            out_beat_o,

    output logic             irq_o
);

    fifo_ctrl_t   fifo_ctrl;
    fifo_status_t fifo_status;

    buffer_regs u_regs (
        .clk_i, .reset_ni,
        .s_axil_awaddr_i, .s_axil_awvalid_i, .s_axil_awready_o,
        .s_axil_wdata_i, .s_axil_wstrb_i, .s_axil_wvalid_i, .s_axil_wready_o,
        .s_axil_bresp_o, .s_axil_bvalid_o, .s_axil_bready_i,
        .s_axil_araddr_i, .s_axil_arvalid_i, .s_axil_arready_o,
        .s_axil_rdata_o, .s_axil_rresp_o, .s_axil_rvalid_o, .s_axil_rready_i,
        .status_i (fifo_status),
        .ctrl_o   (fifo_ctrl),
        .irq_o
    );

    stream_fifo u_fifo (
        .clk_i, .reset_ni,
        .ctrl_i   (fifo_ctrl),
        .in_valid_i, .in_beat_i, .in_full_o,
        .out_ready_i, .out_valid_o, .out_beat_o,
        .status_o (fifo_status)
    );

endmodule

`default_nettype wire

/* verilog/stream_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sample_buffer_macros.svh"

module stream_fifo
    import sample_buffer_pkg::*;
(
    input  wire logic   clk_i,
    input  wire logic   reset_ni,

    input  wire fifo_ctrl_t ctrl_i,

    input  wire logic   in_valid_i,
    input  wire beat_t  in_beat_i,
    output logic        in_full_o,

    input  wire logic   out_ready_i,
    output logic        out_valid_o,
    output beat_t       out_beat_o,

    output fifo_status_t status_o
);

    localparam int unsigned DEPTH = `SB_FIFO_DEPTH;
    localparam int unsigned AW = `SB_PTR_WIDTH;

    beat_t mem [DEPTH];

    // Pointers carry one wrap bit above the address bits
    logic [AW:0]   wr_ptr;
    logic [AW:0]   rd_ptr;
    logic [AW-1:0] wr_addr;
    logic [AW-1:0] rd_addr;
    logic          addr_equal;
    logic          wrap_equal;
    logic          full_now;
    logic          empty_now;
    level_t        fill_now;
    logic          wr_fire;
    logic          rd_fire;
    logic          drop_fire;

    assign wr_addr    = wr_ptr[AW-1:0];
    assign rd_addr    = rd_ptr[AW-1:0];
    assign addr_equal = (wr_addr == rd_addr);
    assign wrap_equal = (wr_ptr[AW] == rd_ptr[AW]);
    assign full_now   = addr_equal && !wrap_equal;
    assign empty_now  = addr_equal && wrap_equal;
    assign fill_now   = wr_ptr - rd_ptr;

    // Acceptance looks at the live pointers, not at the registered flags.
    // A clear pulse wins over any transfer in the same cycle
    assign wr_fire   = ctrl_i.enable && in_valid_i && !full_now && !ctrl_i.clear;
    assign drop_fire = ctrl_i.enable && in_valid_i && full_now;
    assign rd_fire   = out_ready_i && !empty_now && !ctrl_i.clear;

    always_ff @(posedge clk_i) begin
        if (wr_fire) begin
            mem[wr_addr] <= in_beat_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (ctrl_i.clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Head entry is shown every cycle, which lets the consumer peek
    // before it raises ready
    always_ff @(posedge clk_i) begin
        out_beat_o <= mem[rd_addr];
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= rd_fire;
        end
    end

    // Exported status lags the pointers by one cycle
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            status_o <= '{level: '0, empty: 1'b1, full: 1'b0, drop: 1'b0};
        end else begin
            status_o.level <= fill_now;
            status_o.empty <= empty_now;
            status_o.full  <= full_now;
            status_o.drop  <= drop_fire;
        end
    end

    assign in_full_o = status_o.full;

    // A write into a full memory or a read from an empty one would push
    // the pointer distance out of range
    a_fill_range: assert property (@(posedge clk_i) disable iff (!reset_ni)
        fill_now <= level_t'(DEPTH));

endmodule

`default_nettype wire
